//--- bench/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
    import decode_pkg::*;

    localparam int N_INSTR        = 2000;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = N_INSTR * 2 + RESET_CYCLES + 100;

    // Non-jump R-type functions and the immediate arithmetic opcodes
    localparam logic [5:0] R_FUNCTS [13] = '{FUNC_SLL, FUNC_SRL, FUNC_SRA, FUNC_SLLV,
        FUNC_SRLV, FUNC_SRAV, FUNC_ADDU, FUNC_SUBU, FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_NOR,
        FUNC_SLT};
    localparam logic [5:0] IMM_OPCS [6] = '{OPC_ADDI, OPC_SLTI, OPC_ANDI, OPC_ORI,
        OPC_XORI, OPC_LUI};

    typedef struct packed {
        logic [31:0] due;         // Cycle in which o_valid must show this entry
        logic [31:0] instr;
        logic        check_ctrl;  // Low for illegal opcodes where only the masking matters
        logic [1:0]  alu_src_a;
        logic        alu_src_b;
        logic [1:0]  alu_dst;
        logic [3:0]  alu_op;
        logic        agu_src_addr;
        logic [2:0]  agu_op;
        logic        jump;
        logic        branch;
        logic        reg_wr_en;
        logic        mem_wr_en;
        logic        wb_src;
        logic [31:0] imm_ext;
        logic [4:0]  link_reg;
        logic [4:0]  addr_reg;
        logic        illegal;
    } expect_t;

    logic        clk;
    logic        i_arst_n;
    logic        i_valid;
    logic [31:0] i_instr;
    logic        o_valid;
    logic [1:0]  o_alu_src_a;
    logic        o_alu_src_b;
    logic [1:0]  o_alu_dst;
    alu_op_e     o_alu_op;
    logic        o_agu_src_addr;
    agu_op_e     o_agu_op;
    logic        o_jump;
    logic        o_branch;
    logic        o_reg_wr_en;
    logic        o_mem_wr_en;
    logic        o_wb_src;
    logic [31:0] o_imm_ext;
    logic [4:0]  o_link_reg;
    logic [4:0]  o_addr_reg;
    logic        o_illegal;

    logic [31:0] lcg_state   = 32'd31228;
    logic [31:0] cycle_count = 32'd0;
    int          error_count = 0;
    int          n_sent      = 0;
    int          n_checked   = 0;
    expect_t     exp_q [$];   // Instructions in flight, oldest first
    expect_t     cur;         // Values the held outputs must show
    expect_t     next_e;
    logic [31:0] rnd;

    tb_clock_gen u_clock_gen (.o_clk(clk));

    decode_stage u_decode_stage (
        .i_clk          (clk),
        .i_arst_n       (i_arst_n),
        .i_valid        (i_valid),
        .i_instr        (i_instr),
        .o_valid        (o_valid),
        .o_alu_src_a    (o_alu_src_a),
        .o_alu_src_b    (o_alu_src_b),
        .o_alu_dst      (o_alu_dst),
        .o_alu_op       (o_alu_op),
        .o_agu_src_addr (o_agu_src_addr),
        .o_agu_op       (o_agu_op),
        .o_jump         (o_jump),
        .o_branch       (o_branch),
        .o_reg_wr_en    (o_reg_wr_en),
        .o_mem_wr_en    (o_mem_wr_en),
        .o_wb_src       (o_wb_src),
        .o_imm_ext      (o_imm_ext),
        .o_link_reg     (o_link_reg),
        .o_addr_reg     (o_addr_reg),
        .o_illegal      (o_illegal)
    );

    // Two LCG steps, keeping the better upper half of each
    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        hi        = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic logic opcode_known(input logic [5:0] opc);
        case (opc)
            OPC_RTYPE, OPC_J, OPC_JAL, OPC_BEQ, OPC_BNE, OPC_ADDI, OPC_SLTI, OPC_ANDI,
            OPC_ORI, OPC_XORI, OPC_LUI, OPC_LW, OPC_SW: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Picks a class first, then fills the remaining fields at random
    function automatic logic [31:0] make_instr();
        logic [31:0] w;
        logic [31:0] sel;
        w   = rand_word();
        sel = rand_word();
        case (int'(sel % 32'd11))
            0: w = {OPC_RTYPE, w[25:6], R_FUNCTS[int'(rand_word() % 32'd13)]};
            1: w = {OPC_RTYPE, w[25:0]};  // Any function code, mostly unknown
            2: w = {OPC_RTYPE, w[25:6], FUNC_JR};
            3: w = {OPC_RTYPE, w[25:6], FUNC_JALR};
            4: w = {OPC_J, w[25:0]};
            5: w = {OPC_JAL, w[25:0]};
            6: w = {sel[20] ? OPC_BNE : OPC_BEQ, w[25:0]};
            7: w = {IMM_OPCS[int'(rand_word() % 32'd6)], w[25:0]};
            8: w = {OPC_LW, w[25:0]};
            9: w = {OPC_SW, w[25:0]};
            default: begin
                w[31:26] = sel[25:20];
                while (opcode_known(w[31:26])) begin
                    w[31:26] = w[31:26] + 6'd1;  // Step to an unused opcode
                end
            end
        endcase
        return w;
    endfunction

    // Expected outputs from the decode tables
    function automatic expect_t decode_model(input logic [31:0] instr);
        expect_t    e;
        logic [5:0] opc;
        logic [5:0] fn;
        logic [3:0] r_op;
        logic       r_sb;
        logic       r_ok;
        ext_mode_e  mode;
        e          = '0;
        opc        = instr[31:26];
        fn         = instr[5:0];
        r_op       = 4'd0;
        r_sb       = 1'b0;
        r_ok       = 1'b1;
        mode       = EXT_SIGN;  // Every class without its own extension rule
        e.instr      = instr;
        e.check_ctrl = 1'b1;
        e.link_reg   = (opc == OPC_JAL) ? REG_RA : instr[15:11];
        e.addr_reg   = instr[25:21];
        case (opc)
            OPC_RTYPE: begin
                case (fn)
                    FUNC_SLL:  begin r_op = OP_SHIFT_LEFT; r_sb = 1'b1; end
                    FUNC_SRL:  begin r_op = OP_SHIFT_RIGHT; r_sb = 1'b1; end
                    FUNC_SRA:  begin r_op = OP_SHIFT_RIGHT_ARIT; r_sb = 1'b1; end
                    FUNC_SLLV: r_op = OP_SHIFT_LEFT;
                    FUNC_SRLV: r_op = OP_SHIFT_RIGHT;
                    FUNC_SRAV: r_op = OP_SHIFT_RIGHT_ARIT;
                    FUNC_ADDU: r_op = OP_ADD;
                    FUNC_SUBU: r_op = OP_SUB;
                    FUNC_AND:  r_op = OP_AND;
                    FUNC_OR:   r_op = OP_OR;
                    FUNC_XOR:  r_op = OP_XOR;
                    FUNC_NOR:  r_op = OP_NOR;
                    FUNC_SLT:  r_op = OP_SLT;
                    default:   r_ok = 1'b0;
                endcase
                if (fn == FUNC_JR) begin
                    e.jump = 1'b1;  // Register source, AGU_REG is zero
                end else if (fn == FUNC_JALR) begin
                    e.alu_src_a = SRC_A_PC4;
                    e.alu_dst   = DST_RD;
                    e.alu_op    = OP_PASS;
                    e.jump      = 1'b1;
                    e.reg_wr_en = 1'b1;
                    e.wb_src    = 1'b1;
                end else if (r_ok) begin
                    e.alu_src_a = SRC_A_RT;
                    e.alu_src_b = r_sb;
                    e.alu_dst   = DST_RD;
                    e.alu_op    = r_op;
                    e.reg_wr_en = 1'b1;
                    e.wb_src    = 1'b1;
                end
            end
            OPC_J, OPC_JAL: begin
                e.alu_src_a    = SRC_A_PC4;
                e.alu_dst      = DST_RA;
                e.alu_op       = OP_PASS;
                e.agu_src_addr = 1'b1;
                e.agu_op       = AGU_PSEUDO_DIR;
                e.jump         = 1'b1;
                e.reg_wr_en    = (opc == OPC_JAL);
                e.wb_src       = 1'b1;
            end
            OPC_BEQ, OPC_BNE: begin
                e.alu_src_a    = SRC_A_RT;
                e.alu_op       = OP_CMP;
                e.agu_src_addr = 1'b1;
                e.agu_op       = AGU_PC_REL;
                e.branch       = 1'b1;
            end
            OPC_ADDI, OPC_SLTI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI: begin
                e.alu_src_a = SRC_A_IMM;
                e.alu_dst   = DST_RT;
                e.reg_wr_en = 1'b1;
                e.wb_src    = 1'b1;
                case (opc)
                    OPC_ADDI: e.alu_op = OP_SIGNED_ADD;
                    OPC_SLTI: e.alu_op = OP_SLT;
                    OPC_ANDI: begin e.alu_op = OP_AND; mode = EXT_ZERO_UPPER; end
                    OPC_ORI:  begin e.alu_op = OP_OR; mode = EXT_ZERO_UPPER; end
                    OPC_XORI: begin e.alu_op = OP_XOR; mode = EXT_ZERO_UPPER; end
                    default:  begin e.alu_op = OP_PASS; mode = EXT_ZERO_LOWER; end  // LUI
                endcase
            end
            OPC_LW, OPC_SW: begin
                e.alu_dst   = DST_RT;
                e.agu_op    = AGU_BASE_OFFS;
                e.reg_wr_en = (opc == OPC_LW);  // Write-back source stays memory
                e.mem_wr_en = (opc == OPC_SW);
            end
            default: begin
                e.illegal    = 1'b1;  // No write of any kind
                e.check_ctrl = 1'b0;
            end
        endcase
        case (mode)
            EXT_ZERO_UPPER: e.imm_ext = {16'h0000, instr[15:0]};
            EXT_ZERO_LOWER: e.imm_ext = {instr[15:0], 16'h0000};
            default:        e.imm_ext = {{16{instr[15]}}, instr[15:0]};
        endcase
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h (cycle %0d, instr %h)",
                     name, got, exp, cycle_count, cur.instr);
            error_count++;
        end
    endtask

    task automatic compare_outputs(input expect_t e);
        if (e.check_ctrl) begin
            check_value("o_alu_src_a", 32'(o_alu_src_a), 32'(e.alu_src_a));
            check_value("o_alu_src_b", 32'(o_alu_src_b), 32'(e.alu_src_b));
            check_value("o_alu_dst", 32'(o_alu_dst), 32'(e.alu_dst));
            check_value("o_alu_op", 32'(o_alu_op), 32'(e.alu_op));
            check_value("o_agu_src_addr", 32'(o_agu_src_addr), 32'(e.agu_src_addr));
            check_value("o_agu_op", 32'(o_agu_op), 32'(e.agu_op));
            check_value("o_jump", 32'(o_jump), 32'(e.jump));
            check_value("o_branch", 32'(o_branch), 32'(e.branch));
            check_value("o_wb_src", 32'(o_wb_src), 32'(e.wb_src));
        end
        check_value("o_reg_wr_en", 32'(o_reg_wr_en), 32'(e.reg_wr_en));
        check_value("o_mem_wr_en", 32'(o_mem_wr_en), 32'(e.mem_wr_en));
        check_value("o_imm_ext", o_imm_ext, e.imm_ext);
        check_value("o_link_reg", 32'(o_link_reg), 32'(e.link_reg));
        check_value("o_addr_reg", 32'(o_addr_reg), 32'(e.addr_reg));
        check_value("o_illegal", 32'(o_illegal), 32'(e.illegal));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 32'd1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d instructions still pending, %0d errors",
                     cycle_count, exp_q.size(), error_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Outputs are stable mid-cycle, between the capturing edges
    always @(negedge clk) begin
        if (i_arst_n) begin
            if (o_valid) begin
                if (exp_q.size() == 0) begin
                    $display("o_valid went high in cycle %0d with no instruction in flight",
                             cycle_count);
                    error_count++;
                end else begin
                    if (exp_q[0].due != cycle_count) begin
                        $display("o_valid for instr %h came in cycle %0d instead of %0d",
                                 exp_q[0].instr, cycle_count, exp_q[0].due);
                        error_count++;
                    end
                    cur = exp_q.pop_front();
                    n_checked++;
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cycle_count) begin
                $display("No o_valid for instr %h, due in cycle %0d",
                         exp_q[0].instr, exp_q[0].due);
                error_count++;
                void'(exp_q.pop_front());
            end
            compare_outputs(cur);  // Also checks that idle cycles hold the last result
        end
    end

    initial begin
        i_arst_n = 1'b0;
        i_valid  = 1'b0;
        i_instr  = 32'h0000_0000;
        cur            = '0;  // Reset state, every output zero
        cur.check_ctrl = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 i_arst_n = 1'b1;

        while (n_sent < N_INSTR) begin
            @(posedge clk);
            #2;
            rnd     = rand_word();
            i_instr = make_instr();  // Idle cycles carry garbage that must be ignored
            if (rnd[31:30] != 2'b00) begin
                next_e     = decode_model(i_instr);
                next_e.due = cycle_count + 32'd1;
                exp_q.push_back(next_e);
                i_valid = 1'b1;
                n_sent++;
            end else begin
                i_valid = 1'b0;
            end
        end
        @(posedge clk);
        #2 i_valid = 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(negedge clk);

        if (n_checked != n_sent) begin
            $display("Sent %0d instructions but saw only %0d results", n_sent, n_checked);
            error_count++;
        end
        $display("Checked %0d of %0d instructions, %0d errors", n_checked, n_sent, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk  // Free-running clock with a 20 ns period
);

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;  // Half period
    end

endmodule

//--- hw/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                  i_flg_pc_modify,  // Jump or branch
    input  logic                  i_flg_link_ret,   // Saves the return address
    input  logic [1:0]            i_flg_addr_type,  // Register, pseudo-direct or PC-relative
    input  logic                  i_flg_immediate,  // Uses the 16-bit immediate
    input  logic                  i_flg_mem_op,     // Load or store
    input  logic                  i_flg_mem_type,   // Low for load, high for store
    input  logic [5:0]            i_funct,          // R-type or I-type function code
    output logic [1:0]            o_alu_src_a,      // PC+4, RT or extended immediate
    output logic                  o_alu_src_b,      // High selects the shift amount
    output logic [1:0]            o_alu_dst,        // RT, RD or register 31
    output decode_pkg::alu_op_e   o_alu_op,
    output logic                  o_agu_src_addr,   // High for PC, low for a register
    output decode_pkg::agu_op_e   o_agu_op,
    output logic                  o_jump,
    output logic                  o_branch,         // ALU result decides the branch
    output logic                  o_reg_wr_en,
    output logic                  o_mem_wr_en,
    output logic                  o_wb_src,         // High for the ALU, low for data memory
    output decode_pkg::ext_mode_e o_ext_mode        // Immediate extension for the extender
);
    import decode_pkg::*;

    logic [5:0] flags;
    logic       r_known;  // Function code maps to an ALU op

    // Class pattern, most significant bit first
    assign flags = {i_flg_pc_modify, i_flg_link_ret, i_flg_addr_type,
                    i_flg_immediate, i_flg_mem_op};

    always_comb begin
        o_alu_src_a    = 2'b00;  // Everything zero unless a class drives it
        o_alu_src_b    = 1'b0;
        o_alu_dst      = 2'b00;
        o_alu_op       = OP_SHIFT_RIGHT;
        o_agu_src_addr = 1'b0;
        o_agu_op       = AGU_REG;
        o_jump         = 1'b0;
        o_branch       = 1'b0;
        o_reg_wr_en    = 1'b0;
        o_mem_wr_en    = 1'b0;
        o_wb_src       = 1'b0;
        o_ext_mode     = EXT_SIGN;
        r_known        = 1'b1;
        case (flags)
            {2'b00, ADDR_REG, 2'b00}: begin     // R-type
                case (i_funct)
                    FUNC_SLL:  begin o_alu_src_b = 1'b1; o_alu_op = OP_SHIFT_LEFT; end
                    FUNC_SRL:  begin o_alu_src_b = 1'b1; o_alu_op = OP_SHIFT_RIGHT; end
                    FUNC_SRA:  begin o_alu_src_b = 1'b1; o_alu_op = OP_SHIFT_RIGHT_ARIT; end
                    FUNC_SLLV: o_alu_op = OP_SHIFT_LEFT;
                    FUNC_SRLV: o_alu_op = OP_SHIFT_RIGHT;
                    FUNC_SRAV: o_alu_op = OP_SHIFT_RIGHT_ARIT;
                    FUNC_ADDU: o_alu_op = OP_ADD;
                    FUNC_SUBU: o_alu_op = OP_SUB;
                    FUNC_AND:  o_alu_op = OP_AND;
                    FUNC_OR:   o_alu_op = OP_OR;
                    FUNC_XOR:  o_alu_op = OP_XOR;
                    FUNC_NOR:  o_alu_op = OP_NOR;
                    FUNC_SLT:  o_alu_op = OP_SLT;
                    default:   r_known = 1'b0;  // Unknown function leaves all controls at zero
                endcase
                if (r_known) begin
                    o_alu_src_a = SRC_A_RT;
                    o_alu_dst   = DST_RD;
                    o_reg_wr_en = 1'b1;
                    o_wb_src    = 1'b1;
                end
            end
            {2'b10, ADDR_REG, 2'b00}: begin     // JR
                o_agu_op = AGU_REG;             // Target straight from rs
                o_jump   = 1'b1;
            end
            {2'b11, ADDR_REG, 2'b00}: begin     // JALR
                o_alu_src_a = SRC_A_PC4;        // Return address passes the ALU into rd
                o_alu_dst   = DST_RD;
                o_alu_op    = OP_PASS;
                o_agu_op    = AGU_REG;
                o_jump      = 1'b1;
                o_reg_wr_en = 1'b1;
                o_wb_src    = 1'b1;
            end
            {2'b00, ADDR_REG, 2'b11}: begin     // Load and store
                o_alu_dst   = DST_RT;
                o_agu_op    = AGU_BASE_OFFS;
                o_reg_wr_en = ~i_flg_mem_type;  // Only loads write a register
                o_mem_wr_en = i_flg_mem_type;
                o_ext_mode  = EXT_SIGN;         // Offset is signed
            end
            {2'b00, ADDR_REG, 2'b10}: begin     // Arithmetic with an immediate
                o_alu_src_a = SRC_A_IMM;
                o_alu_dst   = DST_RT;
                o_reg_wr_en = 1'b1;
                o_wb_src    = 1'b1;
                case (i_funct)
                    FUNC_ADDI: o_alu_op = OP_SIGNED_ADD;
                    FUNC_SLTI: o_alu_op = OP_SLT;
                    FUNC_ANDI: begin o_alu_op = OP_AND; o_ext_mode = EXT_ZERO_UPPER; end
                    FUNC_ORI:  begin o_alu_op = OP_OR;  o_ext_mode = EXT_ZERO_UPPER; end
                    FUNC_XORI: begin o_alu_op = OP_XOR; o_ext_mode = EXT_ZERO_UPPER; end
                    FUNC_LUI:  begin o_alu_op = OP_PASS; o_ext_mode = EXT_ZERO_LOWER; end
                    default:   o_alu_op = OP_SHIFT_RIGHT;
                endcase
            end
            {2'b10, ADDR_PC_REL, 2'b10}: begin  // BEQ and BNE
                o_alu_src_a    = SRC_A_RT;      // Compare rs against rt
                o_alu_op       = OP_CMP;
                o_agu_src_addr = 1'b1;
                o_agu_op       = AGU_PC_REL;
                o_branch       = 1'b1;
                o_ext_mode     = EXT_SIGN;
            end
            {2'b10, ADDR_PSEUDO, 2'b00},
            {2'b11, ADDR_PSEUDO, 2'b00}: begin  // J and JAL
                o_alu_src_a    = SRC_A_PC4;
                o_alu_dst      = DST_RA;
                o_alu_op       = OP_PASS;
                o_agu_src_addr = 1'b1;
                o_agu_op       = AGU_PSEUDO_DIR;
                o_jump         = 1'b1;
                o_reg_wr_en    = i_flg_link_ret;  // Only JAL saves the return address
                o_wb_src       = 1'b1;
            end
            default: ;  // Other flag patterns keep every output at zero
        endcase
    end

endmodule

//--- hw/decode_pkg.sv
package decode_pkg;

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] OPC_RTYPE = 6'b000000;  // Operation given by the function field
    localparam logic [5:0] OPC_J     = 6'b000010;
    localparam logic [5:0] OPC_JAL   = 6'b000011;
    localparam logic [5:0] OPC_BEQ   = 6'b000100;
    localparam logic [5:0] OPC_BNE   = 6'b000101;
    localparam logic [5:0] OPC_ADDI  = 6'b001000;
    localparam logic [5:0] OPC_SLTI  = 6'b001010;
    localparam logic [5:0] OPC_ANDI  = 6'b001100;
    localparam logic [5:0] OPC_ORI   = 6'b001101;
    localparam logic [5:0] OPC_XORI  = 6'b001110;
    localparam logic [5:0] OPC_LUI   = 6'b001111;
    localparam logic [5:0] OPC_LW    = 6'b100011;
    localparam logic [5:0] OPC_SW    = 6'b101011;

    // R-type function codes, instr[5:0]
    localparam logic [5:0] FUNC_SLL  = 6'b000000;  // Shift amount taken from the sa field
    localparam logic [5:0] FUNC_SRL  = 6'b000010;
    localparam logic [5:0] FUNC_SRA  = 6'b000011;
    localparam logic [5:0] FUNC_SLLV = 6'b000100;  // Shift amount taken from a register
    localparam logic [5:0] FUNC_SRLV = 6'b000110;
    localparam logic [5:0] FUNC_SRAV = 6'b000111;
    localparam logic [5:0] FUNC_JR   = 6'b001000;
    localparam logic [5:0] FUNC_JALR = 6'b001001;
    localparam logic [5:0] FUNC_ADDU = 6'b100001;
    localparam logic [5:0] FUNC_SUBU = 6'b100011;
    localparam logic [5:0] FUNC_AND  = 6'b100100;
    localparam logic [5:0] FUNC_OR   = 6'b100101;
    localparam logic [5:0] FUNC_XOR  = 6'b100110;
    localparam logic [5:0] FUNC_NOR  = 6'b100111;
    localparam logic [5:0] FUNC_SLT  = 6'b101010;

    // I-type function codes are the low three opcode bits
    localparam logic [5:0] FUNC_ADDI = 6'b000000;
    localparam logic [5:0] FUNC_SLTI = 6'b000010;
    localparam logic [5:0] FUNC_ANDI = 6'b000100;
    localparam logic [5:0] FUNC_ORI  = 6'b000101;
    localparam logic [5:0] FUNC_XORI = 6'b000110;
    localparam logic [5:0] FUNC_LUI  = 6'b000111;

    typedef enum logic [3:0] {
        OP_SHIFT_RIGHT      = 4'b0000,
        OP_SHIFT_LEFT       = 4'b0001,
        OP_SHIFT_RIGHT_ARIT = 4'b0010,
        OP_PASS             = 4'b0011,  // Source A goes straight to the result
        OP_ADD              = 4'b0100,
        OP_SUB              = 4'b0101,
        OP_AND              = 4'b0110,
        OP_OR               = 4'b0111,
        OP_XOR              = 4'b1000,
        OP_NOR              = 4'b1001,
        OP_SLT              = 4'b1010,
        OP_CMP              = 4'b1011,  // Branch condition compare
        OP_SIGNED_ADD       = 4'b1100   // Add with overflow detection
    } alu_op_e;

    typedef enum logic [2:0] {
        AGU_REG        = 3'b000,  // Target address held in a register
        AGU_BASE_OFFS  = 3'b001,  // Base register plus offset
        AGU_PC_REL     = 3'b010,  // PC plus offset shifted by two
        AGU_PSEUDO_DIR = 3'b011   // PC high bits joined to the 26-bit target
    } agu_op_e;

    typedef enum logic [1:0] {
        EXT_SIGN       = 2'b00,
        EXT_ZERO_UPPER = 2'b01,
        EXT_ZERO_LOWER = 2'b10
    } ext_mode_e;

    localparam logic [1:0] SRC_A_PC4 = 2'b00;  // Return address for links
    localparam logic [1:0] SRC_A_RT  = 2'b01;
    localparam logic [1:0] SRC_A_IMM = 2'b11;  // Output of the immediate extender

    localparam logic [1:0] DST_RT = 2'b00;
    localparam logic [1:0] DST_RD = 2'b01;
    localparam logic [1:0] DST_RA = 2'b11;     // Register 31

    localparam logic [1:0] ADDR_REG    = 2'b00;
    localparam logic [1:0] ADDR_PSEUDO = 2'b01;
    localparam logic [1:0] ADDR_PC_REL = 2'b10;

    localparam logic [4:0] REG_RA = 5'd31;     // Link register of JAL

endpackage

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_valid,         // One-cycle strobe with a new instruction
    input  logic [31:0]         i_instr,
    output logic                o_valid,         // Decoded set was captured on the last edge
    output logic [1:0]          o_alu_src_a,
    output logic                o_alu_src_b,
    output logic [1:0]          o_alu_dst,
    output decode_pkg::alu_op_e o_alu_op,
    output logic                o_agu_src_addr,
    output decode_pkg::agu_op_e o_agu_op,
    output logic                o_jump,
    output logic                o_branch,
    output logic                o_reg_wr_en,     // Low for illegal instructions
    output logic                o_mem_wr_en,     // Low for illegal instructions
    output logic                o_wb_src,
    output logic [31:0]         o_imm_ext,
    output logic [4:0]          o_link_reg,
    output logic [4:0]          o_addr_reg,
    output logic                o_illegal
);
    import decode_pkg::*;

    logic        pc_modify;
    logic        link_ret;
    logic [1:0]  addr_type;
    logic        immediate;
    logic        mem_op;
    logic        mem_type;
    logic [5:0]  funct;
    logic [4:0]  link_reg;
    logic [4:0]  addr_reg;
    logic        illegal;
    logic [1:0]  alu_src_a;
    logic        alu_src_b;
    logic [1:0]  alu_dst;
    alu_op_e     alu_op;
    logic        agu_src_addr;
    agu_op_e     agu_op;
    logic        jump;
    logic        branch;
    logic        reg_wr_en;
    logic        mem_wr_en;
    logic        wb_src;
    ext_mode_e   ext_mode;
    logic [31:0] imm_ext;

    opcode_decoder u_opcode_decoder (
        .i_instr         (i_instr),
        .o_flg_pc_modify (pc_modify),
        .o_flg_link_ret  (link_ret),
        .o_flg_addr_type (addr_type),
        .o_flg_immediate (immediate),
        .o_flg_mem_op    (mem_op),
        .o_flg_mem_type  (mem_type),
        .o_funct         (funct),
        .o_link_reg      (link_reg),
        .o_addr_reg      (addr_reg),
        .o_illegal       (illegal)
    );

    control_unit u_control_unit (
        .i_flg_pc_modify (pc_modify),
        .i_flg_link_ret  (link_ret),
        .i_flg_addr_type (addr_type),
        .i_flg_immediate (immediate),
        .i_flg_mem_op    (mem_op),
        .i_flg_mem_type  (mem_type),
        .i_funct         (funct),
        .o_alu_src_a     (alu_src_a),
        .o_alu_src_b     (alu_src_b),
        .o_alu_dst       (alu_dst),
        .o_alu_op        (alu_op),
        .o_agu_src_addr  (agu_src_addr),
        .o_agu_op        (agu_op),
        .o_jump          (jump),
        .o_branch        (branch),
        .o_reg_wr_en     (reg_wr_en),
        .o_mem_wr_en     (mem_wr_en),
        .o_wb_src        (wb_src),
        .o_ext_mode      (ext_mode)
    );

    imm_extender u_imm_extender (
        .i_imm     (i_instr[15:0]),
        .i_mode    (ext_mode),
        .o_imm_ext (imm_ext)
    );

    // Pipeline register, loaded only on a strobe and held until the next one
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid        <= 1'b0;
            o_alu_src_a    <= 2'b00;
            o_alu_src_b    <= 1'b0;
            o_alu_dst      <= 2'b00;
            o_alu_op       <= OP_SHIFT_RIGHT;  // Encoding zero
            o_agu_src_addr <= 1'b0;
            o_agu_op       <= AGU_REG;         // Encoding zero
            o_jump         <= 1'b0;
            o_branch       <= 1'b0;
            o_reg_wr_en    <= 1'b0;
            o_mem_wr_en    <= 1'b0;
            o_wb_src       <= 1'b0;
            o_imm_ext      <= 32'h0000_0000;
            o_link_reg     <= 5'd0;
            o_addr_reg     <= 5'd0;
            o_illegal      <= 1'b0;
        end else begin
            o_valid <= i_valid;  // Exactly one cycle per strobe
            if (i_valid) begin
                o_alu_src_a    <= alu_src_a;
                o_alu_src_b    <= alu_src_b;
                o_alu_dst      <= alu_dst;
                o_alu_op       <= alu_op;
                o_agu_src_addr <= agu_src_addr;
                o_agu_op       <= agu_op;
                o_jump         <= jump;
                o_branch       <= branch;
                o_reg_wr_en    <= reg_wr_en & ~illegal;  // Illegal opcodes never write state
                o_mem_wr_en    <= mem_wr_en & ~illegal;
                o_wb_src       <= wb_src;
                o_imm_ext      <= imm_ext;
                o_link_reg     <= link_reg;
                o_addr_reg     <= addr_reg;
                o_illegal      <= illegal;
            end
        end
    end

endmodule

//--- hw/imm_extender.sv
`timescale 1ns/1ps

module imm_extender (
    input  logic [15:0]           i_imm,      // Immediate field of the instruction
    input  decode_pkg::ext_mode_e i_mode,     // Extension picked by the control unit
    output logic [31:0]           o_imm_ext   // Immediate widened to a full word
);
    import decode_pkg::*;

    always_comb begin
        case (i_mode)
            EXT_SIGN:       o_imm_ext = {{16{i_imm[15]}}, i_imm};  // Arithmetic, offsets
            EXT_ZERO_UPPER: o_imm_ext = {16'h0000, i_imm};         // Logic immediates
            EXT_ZERO_LOWER: o_imm_ext = {i_imm, 16'h0000};         // LUI
            default:        o_imm_ext = 32'h0000_0000;
        endcase
    end

endmodule

//--- hw/opcode_decoder.sv
`timescale 1ns/1ps

module opcode_decoder (
    input  logic [31:0] i_instr,          // Instruction word from fetch
    output logic        o_flg_pc_modify,  // Jump or branch
    output logic        o_flg_link_ret,   // Saves the return address
    output logic [1:0]  o_flg_addr_type,  // How the target address is formed
    output logic        o_flg_immediate,  // Uses the 16-bit immediate
    output logic        o_flg_mem_op,     // Load or store
    output logic        o_flg_mem_type,   // Low for load, high for store
    output logic [5:0]  o_funct,          // Function code for the control unit
    output logic [4:0]  o_link_reg,       // Register written with the return address
    output logic [4:0]  o_addr_reg,       // Register holding a jump target or base
    output logic        o_illegal         // Opcode not implemented
);
    import decode_pkg::*;

    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rd;

    assign opcode = i_instr[31:26];
    assign rs     = i_instr[25:21];
    assign rd     = i_instr[15:11];

    // R-type carries its own function field, the I-type ALU ops reuse opcode[2:0]
    assign o_funct    = (opcode == OPC_RTYPE) ? i_instr[5:0] : {3'b000, opcode[2:0]};
    assign o_link_reg = (opcode == OPC_JAL) ? REG_RA : rd;  // JALR links through rd
    assign o_addr_reg = rs;                                 // Target of JR/JALR, base of loads

    always_comb begin
        o_flg_pc_modify = 1'b0;  // Plain R-type pattern unless a class below matches
        o_flg_link_ret  = 1'b0;
        o_flg_addr_type = ADDR_REG;
        o_flg_immediate = 1'b0;
        o_flg_mem_op    = 1'b0;
        o_flg_mem_type  = 1'b0;
        o_illegal       = 1'b0;
        case (opcode)
            OPC_RTYPE: begin
                if (i_instr[5:0] == FUNC_JR || i_instr[5:0] == FUNC_JALR) begin
                    o_flg_pc_modify = 1'b1;                        // Register-indirect jump
                    o_flg_link_ret  = (i_instr[5:0] == FUNC_JALR); // Only JALR links
                end
            end
            OPC_J, OPC_JAL: begin
                o_flg_pc_modify = 1'b1;
                o_flg_link_ret  = (opcode == OPC_JAL);
                o_flg_addr_type = ADDR_PSEUDO;   // 26-bit target replaces the low PC bits
            end
            OPC_BEQ, OPC_BNE: begin
                o_flg_pc_modify = 1'b1;
                o_flg_addr_type = ADDR_PC_REL;   // Offset added to PC+4
                o_flg_immediate = 1'b1;
            end
            OPC_ADDI, OPC_SLTI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI: begin
                o_flg_immediate = 1'b1;          // ALU op picked by opcode[2:0]
            end
            OPC_LW, OPC_SW: begin
                o_flg_immediate = 1'b1;          // Offset for base plus offset
                o_flg_mem_op    = 1'b1;
                o_flg_mem_type  = (opcode == OPC_SW);
            end
            default: o_illegal = 1'b1;   // Flags stay at the R-type pattern, top level masks writes
        endcase
    end

endmodule

//--- project.f
hw/decode_pkg.sv
hw/opcode_decoder.sv
hw/control_unit.sv
hw/imm_extender.sv
hw/decode_stage.sv
bench/tb_clock_gen.sv
bench/decode_stage_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module decode_stage_tb -f project.f -o decode_stage_sim

output=$(./obj_dir/decode_stage_sim)
echo "$output"

if grep -qx "Result: PASSED" <<< "$output"; then
    exit 0
fi
exit 1
